// ==== src/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // load/store width codes
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    // a memory word, whole or per byte lane
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } mem_word_u;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_result;   // effective address for loads/stores
        logic [31:0] rs2_value;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        logic        mem_ren;
        logic        mem_wen;
        logic        reg_wen;
    } ex_mem_s;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        reg_wen;
        logic [2:0]  funct3;
        logic [31:0] pass_value;
        mem_word_u   rdata;        // raw ram word
        logic [1:0]  byte_off;
        logic        is_load;
    } mem_acc_s;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        reg_wen;
        logic [31:0] wb_data;
    } mem_wb_s;

    typedef struct packed {
        logic [29:0] addr;         // word address
        logic        write;
        logic [3:0]  wstrb;
        mem_word_u   wdata;
    } mem_req_s;

endpackage

`default_nettype wire

// ==== src/mem_stage_in.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_in (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             in_valid,
    output logic             in_ready,
    input  lsu_pkg::ex_mem_s in_data,

    output logic             stg_valid,
    input  logic             stg_ready,
    output lsu_pkg::ex_mem_s stg_data
);

    logic             full;
    lsu_pkg::ex_mem_s data_q;
    logic             load;

    // room if empty or draining this cycle
    assign in_ready = ~full | stg_ready;
    assign load     = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (stg_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= in_data;
        end
    end

    assign stg_valid = full;
    assign stg_data  = data_q;

endmodule

`default_nettype wire

// ==== src/lsu_bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_bus_ctrl (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               stg_valid,
    output logic               stg_ready,
    input  lsu_pkg::ex_mem_s   stg_data,

    output logic               req_valid,
    input  logic               req_ready,
    output lsu_pkg::mem_req_s  req,

    input  logic               rsp_valid,
    input  lsu_pkg::mem_word_u rsp_rdata,

    output logic               acc_valid,
    input  logic               acc_ready,
    output lsu_pkg::mem_acc_s  acc_data
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;
    localparam logic [1:0] ST_HAND = 2'd3;

    logic [1:0]         state;
    lsu_pkg::ex_mem_s   cur;
    lsu_pkg::mem_word_u raw_q;
    lsu_pkg::mem_word_u lane_data;
    logic [3:0]         lane_strb;
    logic [1:0]         off;
    logic               is_mem;

    assign stg_ready = (state == ST_IDLE);
    assign req_valid = (state == ST_REQ);
    assign acc_valid = (state == ST_HAND);
    assign is_mem    = stg_data.mem_ren | stg_data.mem_wen;
    assign off       = cur.alu_result[1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (stg_valid) begin
                        state <= is_mem ? ST_REQ : ST_HAND;
                    end
                end
                ST_REQ: begin
                    if (req_ready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rsp_valid) begin
                        state <= ST_HAND;
                    end
                end
                default: begin
                    if (acc_ready) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (stg_valid && stg_ready) begin
            cur <= stg_data;
        end
        if (state == ST_WAIT && rsp_valid) begin
            raw_q <= rsp_rdata;    // stores respond too, word is ignored
        end
    end

    // store lanes and strobes from width and offset
    always_comb begin
        lane_data.word = '0;
        lane_strb      = 4'b0000;
        case (cur.funct3)
            lsu_pkg::f3_byte, lsu_pkg::f3_byte_u: begin
                lane_data.bytes[off] = cur.rs2_value[7:0];
                lane_strb[off]       = 1'b1;
            end
            lsu_pkg::f3_half, lsu_pkg::f3_half_u: begin
                lane_data.bytes[{off[1], 1'b0}] = cur.rs2_value[7:0];
                lane_data.bytes[{off[1], 1'b1}] = cur.rs2_value[15:8];
                lane_strb[{off[1], 1'b0}]       = 1'b1;
                lane_strb[{off[1], 1'b1}]       = 1'b1;
            end
            default: begin
                lane_data.word = cur.rs2_value;
                lane_strb      = 4'b1111;
            end
        endcase
    end

    assign req.addr  = cur.alu_result[31:2];
    assign req.write = cur.mem_wen;
    assign req.wstrb = cur.mem_wen ? lane_strb : 4'b0000;
    assign req.wdata = lane_data;

    assign acc_data.pc         = cur.pc;
    assign acc_data.rd         = cur.rd;
    assign acc_data.reg_wen    = cur.reg_wen;
    assign acc_data.funct3     = cur.funct3;
    assign acc_data.pass_value = cur.alu_result;
    assign acc_data.rdata      = raw_q;
    assign acc_data.byte_off   = off;
    assign acc_data.is_load    = cur.mem_ren;

endmodule

`default_nettype wire

// ==== src/load_extend.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_extend (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              acc_valid,
    output logic              acc_ready,
    input  lsu_pkg::mem_acc_s acc_data,

    output logic              out_valid,
    input  logic              out_ready,
    output lsu_pkg::mem_wb_s  out_data
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] wb_next;
    logic        take;

    assign acc_ready = ~out_valid | out_ready;
    assign take      = acc_valid & acc_ready;

    assign sel_byte = acc_data.rdata.bytes[acc_data.byte_off];
    assign sel_half = {acc_data.rdata.bytes[{acc_data.byte_off[1], 1'b1}],
                       acc_data.rdata.bytes[{acc_data.byte_off[1], 1'b0}]};

    always_comb begin
        if (!acc_data.is_load) begin
            wb_next = acc_data.pass_value;    // alu result, stores too
        end else begin
            case (acc_data.funct3)
                lsu_pkg::f3_byte:   wb_next = {{24{sel_byte[7]}}, sel_byte};
                lsu_pkg::f3_half:   wb_next = {{16{sel_half[15]}}, sel_half};
                lsu_pkg::f3_byte_u: wb_next = {24'd0, sel_byte};
                lsu_pkg::f3_half_u: wb_next = {16'd0, sel_half};
                lsu_pkg::f3_word:   wb_next = acc_data.rdata.word;
                default:            wb_next = acc_data.rdata.word;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_data.pc      <= acc_data.pc;
            out_data.rd      <= acc_data.rd;
            out_data.reg_wen <= acc_data.reg_wen;
            out_data.wb_data <= wb_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int DEPTH_WORDS = 256,
    parameter int RAM_LATENCY = 2
) (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               req_valid,
    output logic               req_ready,
    input  lsu_pkg::mem_req_s  req,

    output logic               rsp_valid,
    output lsu_pkg::mem_word_u rsp_rdata
);

    localparam int AW = $clog2(DEPTH_WORDS);
    localparam int CW = $clog2(RAM_LATENCY + 1);

    lsu_pkg::mem_word_u mem [DEPTH_WORDS];
    lsu_pkg::mem_word_u rdata_q;
    logic [CW-1:0]      cnt;
    logic [AW-1:0]      idx;
    logic               accept;

    initial begin
        for (int i = 0; i < DEPTH_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign req_ready = (cnt == '0);    // one access open at a time
    assign accept    = req_valid & req_ready;
    assign idx       = req.addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= mem[idx];
            for (int b = 0; b < 4; b++) begin
                if (req.write && req.wstrb[b]) begin
                    mem[idx].bytes[b] <= req.wdata.bytes[b];
                end
            end
        end
    end

    // latency countdown, response fires as it expires
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= (cnt == CW'(1));
            if (accept) begin
                cnt <= CW'(RAM_LATENCY);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign rsp_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== src/mem_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top #(
    parameter int DEPTH_WORDS = 256,
    parameter int RAM_LATENCY = 2
) (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             in_valid,
    output logic             in_ready,
    input  lsu_pkg::ex_mem_s in_data,

    output logic             out_valid,
    input  logic             out_ready,
    output lsu_pkg::mem_wb_s out_data
);

    logic               stg_valid;
    logic               stg_ready;
    lsu_pkg::ex_mem_s   stg_data;
    logic               acc_valid;
    logic               acc_ready;
    lsu_pkg::mem_acc_s  acc_data;
    logic               req_valid;
    logic               req_ready;
    lsu_pkg::mem_req_s  req;
    logic               rsp_valid;
    lsu_pkg::mem_word_u rsp_rdata;

    mem_stage_in u_in (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .stg_valid (stg_valid),
        .stg_ready (stg_ready),
        .stg_data  (stg_data)
    );

    lsu_bus_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .stg_valid (stg_valid),
        .stg_ready (stg_ready),
        .stg_data  (stg_data),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .acc_valid (acc_valid),
        .acc_ready (acc_ready),
        .acc_data  (acc_data)
    );

    load_extend u_ext (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_valid (acc_valid),
        .acc_ready (acc_ready),
        .acc_data  (acc_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    data_ram #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .RAM_LATENCY (RAM_LATENCY)
    ) u_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata)
    );

endmodule

`default_nettype wire

// ==== tests/mem_stage_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               req_valid,
    input logic               req_ready,
    input lsu_pkg::mem_req_s  req,
    input logic               rsp_valid,
    input logic               acc_valid,
    input logic               acc_ready,
    input lsu_pkg::mem_acc_s  acc_data
);

    logic pending;    // request accepted, response not yet seen

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (req_valid && req_ready) begin
            pending <= 1'b1;
        end else if (rsp_valid) begin
            pending <= 1'b0;
        end
    end

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("request dropped or changed before acceptance");

    acc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        acc_valid && !acc_ready |=> acc_valid && $stable(acc_data))
        else $error("acc record dropped or changed before acceptance");

    one_open: assert property (@(posedge clk) disable iff (!rst_n)
        pending |-> !req_valid)
        else $error("request issued while a response is pending");

    rsp_match: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> pending)
        else $error("response without an open request");

endmodule

bind lsu_bus_ctrl mem_stage_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .acc_valid (acc_valid),
    .acc_ready (acc_ready),
    .acc_data  (acc_data)
);

`default_nettype wire

// ==== tests/tb_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

    localparam int RAM_LATENCY = 2;
    localparam int DEPTH_WORDS = 256;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic             in_ready;
    lsu_pkg::ex_mem_s in_data;
    logic             out_valid;
    logic             out_ready;
    lsu_pkg::mem_wb_s out_data;

    lsu_pkg::ex_mem_s vec_in [$];
    lsu_pkg::mem_wb_s exp_q [$];
    int               grp_q [$];
    logic [7:0]       model_mem [1024];    // byte-lane view of the data ram

    int n_vec    = 0;
    int limit    = 1000;
    int cycles   = 0;
    int out_cnt  = 0;
    int pass_cnt = 0;
    int err_cnt  = 0;
    int cur_grp  = 0;
    int grp_pass = 0;
    int grp_err  = 0;
    bit held     = 0;
    lsu_pkg::mem_wb_s held_data;

    always #50 clk = ~clk;

    mem_stage_top #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .RAM_LATENCY (RAM_LATENCY)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    function automatic string group_name(input int grp);
        case (grp)
            1:       return "pass-through";
            2:       return "store then word load";
            3:       return "narrow stores";
            4:       return "load extension";
            default: return "back-pressure and ordering";
        endcase
    endfunction

    // kind 0 alu, 1 load, 2 store
    task automatic apply_model(input logic [31:0] kind, input logic [2:0] f3,
                               input logic [31:0] addr, input logic [31:0] rs2,
                               output logic [31:0] res);
        logic [9:0] a;
        int         n;
        a   = addr[9:0];
        n   = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
        res = addr;
        if (n == 2) a[0] = 1'b0;
        if (n == 4) a[1:0] = 2'b00;
        if (kind == 2) begin
            for (int b = 0; b < n; b++) model_mem[a + 10'(b)] = rs2[8*b +: 8];
        end else if (kind == 1) begin
            res = '0;
            for (int b = 0; b < n; b++) res[8*b +: 8] = model_mem[a + 10'(b)];
            if (!f3[2] && n < 4 && res[8*n-1]) res = res | (~32'd0 << (8*n));
        end
    endtask

    task automatic read_vectors();
        int               fd;
        int               cnt;
        string            line;
        logic [31:0]      f_grp, f_kind, f_f3, f_addr, f_rs2, f_rd, f_wen, f_exp;
        logic [31:0]      model_val;
        lsu_pkg::ex_mem_s rec;
        lsu_pkg::mem_wb_s wb;
        fd = $fopen("tests/mem_stage_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tests/mem_stage_vectors.txt");
            err_cnt++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;    // header and blank lines
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h",
                          f_grp, f_kind, f_f3, f_addr, f_rs2, f_rd, f_wen, f_exp);
            if (cnt != 8) begin
                $display("malformed vector line skipped: %s", line);
                err_cnt++;
                continue;
            end
            rec            = '0;
            rec.pc         = 32'h1000 + 32'(4 * vec_in.size());
            rec.alu_result = f_addr;
            rec.rs2_value  = f_rs2;
            rec.rd         = f_rd[4:0];
            rec.funct3     = f_f3[2:0];
            rec.mem_ren    = (f_kind == 1);
            rec.mem_wen    = (f_kind == 2);
            rec.reg_wen    = f_wen[0];
            wb.pc          = rec.pc;
            wb.rd          = rec.rd;
            wb.reg_wen     = rec.reg_wen;
            wb.wb_data     = f_exp;
            apply_model(f_kind, f_f3[2:0], f_addr, f_rs2, model_val);
            if (model_val !== f_exp) begin
                $display("vector %0d: file value %h disagrees with the byte-lane model %h",
                         vec_in.size(), f_exp, model_val);
                err_cnt++;
            end
            vec_in.push_back(rec);
            exp_q.push_back(wb);
            grp_q.push_back(int'(f_grp));
        end
        $fclose(fd);
        n_vec = vec_in.size();
        if (n_vec == 0) begin
            $display("no vectors were read, nothing was tested");
            err_cnt++;
        end
    endtask

    task automatic report_group();
        if (cur_grp != 0) begin
            $display("group %0d %s: %0d ok, %0d errors",
                     cur_grp, group_name(cur_grp), grp_pass, grp_err);
        end
        grp_pass = 0;
        grp_err  = 0;
    endtask

    task automatic check_output(input lsu_pkg::mem_wb_s got);
        lsu_pkg::mem_wb_s want;
        int               grp;
        bit               bad;
        bad = 0;
        if (exp_q.size() == 0) begin
            $display("error at %0t: an output record arrived with no input left for it", $time);
            err_cnt++;
            return;
        end
        want = exp_q.pop_front();
        grp  = grp_q.pop_front();
        if (grp != cur_grp) begin
            report_group();
            cur_grp = grp;
        end
        if (got.pc !== want.pc) begin
            $display("error at %0t: out_data.pc expected %h got %h", $time, want.pc, got.pc);
            bad = 1;
        end
        if (got.rd !== want.rd) begin
            $display("error at %0t: out_data.rd expected %h got %h", $time, want.rd, got.rd);
            bad = 1;
        end
        if (got.reg_wen !== want.reg_wen) begin
            $display("error at %0t: out_data.reg_wen expected %b got %b",
                     $time, want.reg_wen, got.reg_wen);
            bad = 1;
        end
        if (got.wb_data !== want.wb_data) begin
            $display("error at %0t: out_data.wb_data expected %h got %h",
                     $time, want.wb_data, got.wb_data);
            bad = 1;
        end
        if (bad) begin
            err_cnt++;
            grp_err++;
        end else begin
            pass_cnt++;
            grp_pass++;
        end
        out_cnt++;
    endtask

    always @(posedge clk) begin
        out_ready <= ($urandom % 100) < 70;    // about 70 percent ready
    end

    // sampled mid-cycle for the transfer on the next rising edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (held && out_data !== held_data) begin
                $display("error at %0t: out_data expected %h (held) got %h",
                         $time, held_data, out_data);
                err_cnt++;
            end
            held      = !out_ready;
            held_data = out_data;
            if (out_ready) check_output(out_data);
        end else if (rst_n && held) begin
            $display("error at %0t: out_valid expected 1 (held) got %b", $time, out_valid);
            err_cnt++;
            held = 0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles: only %0d of %0d outputs arrived",
                     cycles, out_cnt, n_vec);
            $display("the remaining outputs are missing");
            $display("summary: %0d checks passed, %0d errors", pass_cnt, err_cnt + 1);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        for (int i = 0; i < 1024; i++) model_mem[i] = 8'h00;
        void'($urandom(32'h7e334b23));
        read_vectors();
        limit = n_vec * (RAM_LATENCY + 10) + 50;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("error at %0t: out_valid expected 0 got %b", $time, out_valid);
            err_cnt++;
        end
        if (in_ready !== 1'b1) begin
            $display("error at %0t: in_ready expected 1 got %b", $time, in_ready);
            err_cnt++;
        end
        @(posedge clk);
        for (int i = 0; i < n_vec; i++) begin
            in_valid <= 1'b1;
            in_data  <= vec_in[i];
            do @(negedge clk); while (in_ready !== 1'b1);    // accepted on the next edge
            @(posedge clk);
        end
        in_valid <= 1'b0;
        while (out_cnt < n_vec) @(posedge clk);
        repeat (4) @(posedge clk);    // room for a stray extra record
        report_group();
        $display("summary: %0d checks passed, %0d errors", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/mem_stage_vectors.txt ====
# group kind(0 alu, 1 load, 2 store) funct3 addr rs2 rd reg_wen expected_wb, all hex
# pc is assigned by the testbench: 0x1000 plus 4 per vector line
1 0 0 12345678 00000000 05 1 12345678
1 0 0 deadbeef 00000000 1f 1 deadbeef
1 0 0 00000abc 00000000 03 0 00000abc
2 2 2 00000040 cafef00d 00 0 00000040
2 1 2 00000040 00000000 06 1 cafef00d
3 2 0 00000080 000000a1 00 0 00000080
3 2 0 00000081 ffffffb2 00 0 00000081
3 2 0 00000082 000000c3 00 0 00000082
3 2 0 00000083 000000d4 00 0 00000083
3 1 2 00000080 00000000 0a 1 d4c3b2a1
3 2 1 00000084 1234e5f6 00 0 00000084
3 2 1 00000086 00008797 00 0 00000086
3 1 2 00000084 00000000 0b 1 8797e5f6
3 2 1 00000082 00005a5a 00 0 00000082
3 1 2 00000080 00000000 0c 1 5a5ab2a1
4 1 0 00000084 00000000 0d 1 fffffff6
4 1 0 00000085 00000000 0d 1 ffffffe5
4 1 0 00000086 00000000 0d 1 ffffff97
4 1 0 00000087 00000000 0d 1 ffffff87
4 1 4 00000084 00000000 0e 1 000000f6
4 1 4 00000085 00000000 0e 1 000000e5
4 1 4 00000086 00000000 0e 1 00000097
4 1 4 00000087 00000000 0e 1 00000087
4 1 1 00000084 00000000 0f 1 ffffe5f6
4 1 1 00000086 00000000 0f 1 ffff8797
4 1 5 00000084 00000000 10 1 0000e5f6
4 1 5 00000086 00000000 10 1 00008797
4 1 0 00000082 00000000 11 1 0000005a
4 1 1 00000082 00000000 11 1 00005a5a
5 0 0 00000111 00000000 07 1 00000111
5 1 2 00000040 00000000 08 1 cafef00d
5 0 0 00000222 00000000 09 1 00000222
5 1 4 00000083 00000000 0a 1 0000005a
5 2 2 00000088 13572468 00 0 00000088
5 1 2 00000088 00000000 0b 1 13572468
5 0 0 00000333 00000000 0c 1 00000333

// ==== vlog.f ====
src/lsu_pkg.sv
src/mem_stage_in.sv
src/lsu_bus_ctrl.sv
src/load_extend.sv
src/data_ram.sv
src/mem_stage_top.sv
tests/mem_stage_asserts.sv
tests/tb_mem_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP BUILD_DIR LOG FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
